// File: Bender.yml
package:
  name: wb_csr

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/wb_pkg.sv
      - rtl/csr_port_if.sv
      - rtl/trap_if.sv
      - rtl/wb_stage.sv
      - rtl/csr_file.sv
      - rtl/stable_timer.sv
      - rtl/wb_csr_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/wb_csr_tb.sv

// File: include/wb_config.svh
`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

// csr addresses
`define CSR_CRMD    14'h000
`define CSR_PRMD    14'h001
`define CSR_ECFG    14'h004
`define CSR_ESTAT   14'h005
`define CSR_ERA     14'h006
`define CSR_EENTRY  14'h00c
`define CSR_SAVE0   14'h030
`define CSR_SAVE1   14'h031
`define CSR_SAVE2   14'h032
`define CSR_SAVE3   14'h033
`define CSR_TID     14'h040
`define CSR_TCFG    14'h041
`define CSR_TVAL    14'h042
`define CSR_TICLR   14'h044

// exception codes written to estat.ecode
`define ECODE_INT   6'h00
`define ECODE_ADEF  6'h08
`define ECODE_ALE   6'h09
`define ECODE_SYS   6'h0b
`define ECODE_BRK   6'h0c
`define ECODE_INE   6'h0d

// rdcnt variants
`define CNT_OP_NONE 2'd0
`define CNT_OP_TID  2'd1
`define CNT_OP_VL   2'd2
`define CNT_OP_VH   2'd3

`define TIMER_IS_BIT 11 // estat.is bit for the timer interrupt

`endif

// File: rtl/csr_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb_config.svh"

module csr_file (
    input  wire            clk,
    input  wire            resetn,
    csr_port_if.csr        csr,
    trap_if.csr            trap,
    input  wire            timer_tick,
    input  wb_pkg::word_t  tval,
    output wb_pkg::word_t  tcfg,
    output logic           tcfg_we,
    output logic           flush,
    output wb_pkg::pc_t    flush_target,
    output logic           has_int
);
    import wb_pkg::*;

    // writable bits of each csr
    localparam word_t CRMD_WMASK   = 32'h0000_01ff;
    localparam word_t PRMD_WMASK   = 32'h0000_0007;
    localparam word_t ECFG_WMASK   = 32'h0000_1bff;
    localparam word_t ESTAT_WMASK  = 32'h0000_0003; // software interrupts only
    localparam word_t EENTRY_WMASK = 32'hffff_ffc0;
    localparam word_t ALL_WMASK    = 32'hffff_ffff;

    word_t crmd;
    word_t prmd;
    word_t ecfg;
    word_t estat;
    word_t era;
    word_t eentry;
    word_t save [4];
    word_t tid;
    word_t tcfg_q;
    word_t tcfg_next;
    word_t rd_data;
    logic  ticlr_clr;

    function automatic word_t masked_wr(input word_t old_v, input word_t wmask,
                                        input word_t wvalue, input word_t legal);
        word_t m;
        m = wmask & legal;
        return (old_v & ~m) | (wvalue & m);
    endfunction

    function automatic logic hit(input csr_num_t addr);
        return csr.we && (csr.num == addr);
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd <= 32'h0000_0008; // da set out of reset
        end else if (trap.ex) begin
            crmd[2:0] <= 3'b000;  // plv0, ie off
        end else if (trap.ertn) begin
            crmd[2:0] <= prmd[2:0];
        end else if (hit(`CSR_CRMD)) begin
            crmd <= masked_wr(crmd, csr.wmask, csr.wvalue, CRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            prmd <= '0;
        end else if (trap.ex) begin
            prmd[2:0] <= crmd[2:0]; // pplv and pie
        end else if (hit(`CSR_PRMD)) begin
            prmd <= masked_wr(prmd, csr.wmask, csr.wvalue, PRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat <= '0;
        end else begin
            if (hit(`CSR_ESTAT)) begin
                estat <= masked_wr(estat, csr.wmask, csr.wvalue, ESTAT_WMASK);
            end
            if (trap.ex) begin
                estat[21:16] <= trap.ecode;
                estat[30:22] <= trap.esubcode;
            end
            if (ticlr_clr) begin
                estat[`TIMER_IS_BIT] <= 1'b0;
            end
            if (timer_tick) begin
                estat[`TIMER_IS_BIT] <= 1'b1; // a new tick wins over clear
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            era <= '0;
        end else if (trap.ex) begin
            era <= trap.ex_pc;
        end else if (hit(`CSR_ERA)) begin
            era <= masked_wr(era, csr.wmask, csr.wvalue, ALL_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ecfg   <= '0;
            eentry <= '0;
            tid    <= '0;
            tcfg_q <= '0;
            for (int i = 0; i < 4; i++) begin
                save[i] <= '0;
            end
        end else begin
            if (hit(`CSR_ECFG))   ecfg   <= masked_wr(ecfg, csr.wmask, csr.wvalue, ECFG_WMASK);
            if (hit(`CSR_EENTRY)) eentry <= masked_wr(eentry, csr.wmask, csr.wvalue,
                                                      EENTRY_WMASK);
            if (hit(`CSR_TID))    tid    <= masked_wr(tid, csr.wmask, csr.wvalue, ALL_WMASK);
            if (tcfg_we)          tcfg_q <= tcfg_next;
            for (int i = 0; i < 4; i++) begin
                if (hit(csr_num_t'(`CSR_SAVE0 + i))) begin
                    save[i] <= masked_wr(save[i], csr.wmask, csr.wvalue, ALL_WMASK);
                end
            end
        end
    end

    // timer sees the new tcfg during the write cycle so it loads at the same edge
    assign tcfg_we   = hit(`CSR_TCFG);
    assign tcfg_next = masked_wr(tcfg_q, csr.wmask, csr.wvalue, ALL_WMASK);
    assign tcfg      = tcfg_we ? tcfg_next : tcfg_q;

    assign ticlr_clr = hit(`CSR_TICLR) && csr.wmask[0] && csr.wvalue[0];

    always_comb begin
        case (csr.num)
            `CSR_CRMD:   rd_data = crmd;
            `CSR_PRMD:   rd_data = prmd;
            `CSR_ECFG:   rd_data = ecfg;
            `CSR_ESTAT:  rd_data = estat;
            `CSR_ERA:    rd_data = era;
            `CSR_EENTRY: rd_data = eentry;
            `CSR_SAVE0:  rd_data = save[0];
            `CSR_SAVE1:  rd_data = save[1];
            `CSR_SAVE2:  rd_data = save[2];
            `CSR_SAVE3:  rd_data = save[3];
            `CSR_TID:    rd_data = tid;
            `CSR_TCFG:   rd_data = tcfg_q;
            `CSR_TVAL:   rd_data = tval;
            default:     rd_data = '0; // ticlr and unknown read as zero
        endcase
    end

    assign csr.rvalue = csr.re ? rd_data : '0;

    assign flush        = trap.ex || trap.ertn;
    assign flush_target = trap.ex ? eentry : era;

    // ie gates all lines and lie picks which ones
    assign has_int = crmd[2] && (|(estat[12:0] & ecfg[12:0]));

endmodule

`default_nettype wire

// File: rtl/csr_port_if.sv
`timescale 1ns/1ns
`default_nettype none

interface csr_port_if;
    import wb_pkg::*;

    logic     re;
    csr_num_t num;
    word_t    rvalue;  // combinational read data
    logic     we;
    word_t    wmask;   // only set bits are written
    word_t    wvalue;

    modport wb (
        output re, num, we, wmask, wvalue,
        input  rvalue
    );

    modport csr (
        input  re, num, we, wmask, wvalue,
        output rvalue
    );

endinterface

`default_nettype wire

// File: rtl/stable_timer.sv
`timescale 1ns/1ns
`default_nettype none

module stable_timer (
    input  wire            clk,
    input  wire            resetn,
    input  wb_pkg::word_t  tcfg,
    input  wire            tcfg_we,
    output wb_pkg::cnt64_t stable_cnt,
    output wb_pkg::word_t  tval,
    output logic           tick
);
    import wb_pkg::*;

    word_t init_val;
    logic  running;

    assign init_val = {tcfg[31:2], 2'b00}; // initval is a multiple of four

    always_ff @(posedge clk) begin
        if (!resetn) begin
            stable_cnt <= '0;
        end else begin
            stable_cnt <= stable_cnt + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tval    <= '0;
            running <= 1'b0;
        end else if (tcfg_we) begin
            tval    <= init_val;
            running <= tcfg[0];
        end else if (running) begin
            if (tval == '0) begin
                if (tcfg[1]) begin
                    tval <= init_val;  // periodic
                end else begin
                    running <= 1'b0;   // one-shot done
                end
            end else begin
                tval <= tval - 32'd1;
            end
        end
    end

    // high for the one cycle the countdown sits at zero
    assign tick = running && (tval == '0) && !tcfg_we;

endmodule

`default_nettype wire

// File: rtl/trap_if.sv
`timescale 1ns/1ns
`default_nettype none

interface trap_if;
    import wb_pkg::*;

    logic      ex;        // exception taken this cycle
    ecode_t    ecode;
    esubcode_t esubcode;
    pc_t       ex_pc;     // pc of the faulting instruction
    logic      ertn;      // exception return this cycle

    modport wb (
        output ex, ecode, esubcode, ex_pc, ertn
    );

    modport csr (
        input  ex, ecode, esubcode, ex_pc, ertn
    );

endinterface

`default_nettype wire

// File: rtl/wb_csr_top.sv
`timescale 1ns/1ns
`default_nettype none

module wb_csr_top (
    input  wire                  clk,
    input  wire                  resetn,
    input  wire                  mem_valid,
    input  wb_pkg::pc_t          mem_pc,
    input  wire                  mem_rf_we,
    input  wb_pkg::reg_addr_t    mem_rf_waddr,
    input  wb_pkg::word_t        mem_rf_wdata,
    input  wire                  mem_csr_re,
    input  wire                  mem_csr_we,
    input  wb_pkg::csr_num_t     mem_csr_num,
    input  wb_pkg::word_t        mem_csr_wmask,
    input  wb_pkg::word_t        mem_csr_wvalue,
    input  wire                  mem_ertn,
    input  wb_pkg::excp_flags_t  mem_excp,
    input  wb_pkg::esubcode_t    mem_esubcode,
    input  wb_pkg::cnt_op_t      mem_cnt_op,
    output logic                 rf_we,
    output wb_pkg::reg_addr_t    rf_waddr,
    output wb_pkg::word_t        rf_wdata,
    output wb_pkg::pc_t          debug_pc,
    output logic                 flush,
    output wb_pkg::pc_t          flush_target,
    output logic                 has_int
);
    import wb_pkg::*;

    cnt64_t stable_cnt;
    word_t  tval;
    word_t  tcfg;
    logic   tcfg_we;
    logic   timer_tick;

    csr_port_if csr_bus ();
    trap_if     trap_bus ();

    wb_stage wb_stage_i (
        .clk            (clk),
        .resetn         (resetn),
        .mem_valid      (mem_valid),
        .mem_pc         (mem_pc),
        .mem_rf_we      (mem_rf_we),
        .mem_rf_waddr   (mem_rf_waddr),
        .mem_rf_wdata   (mem_rf_wdata),
        .mem_csr_re     (mem_csr_re),
        .mem_csr_we     (mem_csr_we),
        .mem_csr_num    (mem_csr_num),
        .mem_csr_wmask  (mem_csr_wmask),
        .mem_csr_wvalue (mem_csr_wvalue),
        .mem_ertn       (mem_ertn),
        .mem_excp       (mem_excp),
        .mem_esubcode   (mem_esubcode),
        .mem_cnt_op     (mem_cnt_op),
        .stable_cnt     (stable_cnt),
        .csr            (csr_bus.wb),
        .trap           (trap_bus.wb),
        .rf_we          (rf_we),
        .rf_waddr       (rf_waddr),
        .rf_wdata       (rf_wdata),
        .debug_pc       (debug_pc)
    );

    csr_file csr_file_i (
        .clk          (clk),
        .resetn       (resetn),
        .csr          (csr_bus.csr),
        .trap         (trap_bus.csr),
        .timer_tick   (timer_tick),
        .tval         (tval),
        .tcfg         (tcfg),
        .tcfg_we      (tcfg_we),
        .flush        (flush),
        .flush_target (flush_target),
        .has_int      (has_int)
    );

    stable_timer stable_timer_i (
        .clk        (clk),
        .resetn     (resetn),
        .tcfg       (tcfg),
        .tcfg_we    (tcfg_we),
        .stable_cnt (stable_cnt),
        .tval       (tval),
        .tick       (timer_tick)
    );

endmodule

`default_nettype wire

// File: rtl/wb_pkg.sv
`default_nettype none

package wb_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] pc_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [13:0] csr_num_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    // one bit per cause
    // [5] interrupt, [4] adef, [3] ale, [2] syscall, [1] brk, [0] ine
    typedef logic [5:0]  excp_flags_t;

    // none / tid / counter low / counter high as in the CNT_OP_* macros
    typedef logic [1:0]  cnt_op_t;

    typedef logic [63:0] cnt64_t; // stable counter

endpackage

`default_nettype wire

// File: rtl/wb_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb_config.svh"

module wb_stage (
    input  wire                  clk,
    input  wire                  resetn,
    input  wire                  mem_valid,
    input  wb_pkg::pc_t          mem_pc,
    input  wire                  mem_rf_we,
    input  wb_pkg::reg_addr_t    mem_rf_waddr,
    input  wb_pkg::word_t        mem_rf_wdata,
    input  wire                  mem_csr_re,
    input  wire                  mem_csr_we,
    input  wb_pkg::csr_num_t     mem_csr_num,
    input  wb_pkg::word_t        mem_csr_wmask,
    input  wb_pkg::word_t        mem_csr_wvalue,
    input  wire                  mem_ertn,
    input  wb_pkg::excp_flags_t  mem_excp,
    input  wb_pkg::esubcode_t    mem_esubcode,
    input  wb_pkg::cnt_op_t      mem_cnt_op,
    input  wb_pkg::cnt64_t       stable_cnt,
    csr_port_if.wb               csr,
    trap_if.wb                   trap,
    output logic                 rf_we,
    output wb_pkg::reg_addr_t    rf_waddr,
    output wb_pkg::word_t        rf_wdata,
    output wb_pkg::pc_t          debug_pc
);
    import wb_pkg::*;

    logic        wb_valid;
    pc_t         wb_pc;
    logic        wb_rf_we;
    reg_addr_t   wb_rf_waddr;
    word_t       wb_rf_wdata;
    logic        wb_csr_re;
    logic        wb_csr_we;
    csr_num_t    wb_csr_num;
    word_t       wb_csr_wmask;
    word_t       wb_csr_wvalue;
    logic        wb_ertn;
    excp_flags_t wb_excp;
    esubcode_t   wb_esubcode;
    cnt_op_t     wb_cnt_op;

    logic        ex_now;
    logic        ertn_now;
    logic        read_tid;

    // valid drops on flush so any instruction behind it is discarded
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (ex_now || ertn_now) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid) begin
            wb_pc         <= mem_pc;
            wb_rf_we      <= mem_rf_we;
            wb_rf_waddr   <= mem_rf_waddr;
            wb_rf_wdata   <= mem_rf_wdata;
            wb_csr_re     <= mem_csr_re;
            wb_csr_we     <= mem_csr_we;
            wb_csr_num    <= mem_csr_num;
            wb_csr_wmask  <= mem_csr_wmask;
            wb_csr_wvalue <= mem_csr_wvalue;
            wb_ertn       <= mem_ertn;
            wb_excp       <= mem_excp;
            wb_esubcode   <= mem_esubcode;
            wb_cnt_op     <= mem_cnt_op;
        end
    end

    assign ex_now   = wb_valid && (|wb_excp);
    assign ertn_now = wb_valid && wb_ertn && !(|wb_excp);
    assign read_tid = (wb_cnt_op == `CNT_OP_TID);

    // rdcntid goes through the csr read port
    assign csr.re     = wb_valid && (wb_csr_re || read_tid);
    assign csr.num    = read_tid ? `CSR_TID : wb_csr_num;
    assign csr.we     = wb_valid && wb_csr_we && !(|wb_excp);
    assign csr.wmask  = wb_csr_wmask;
    assign csr.wvalue = wb_csr_wvalue;

    always_comb begin
        if (wb_csr_re || read_tid) begin
            rf_wdata = csr.rvalue;
        end else if (wb_cnt_op == `CNT_OP_VL) begin
            rf_wdata = stable_cnt[31:0];
        end else if (wb_cnt_op == `CNT_OP_VH) begin
            rf_wdata = stable_cnt[63:32];
        end else begin
            rf_wdata = wb_rf_wdata; // alu / load result
        end
    end

    assign rf_we    = wb_valid && wb_rf_we && !(|wb_excp);
    assign rf_waddr = wb_rf_waddr;
    assign debug_pc = wb_pc;

    // highest priority first
    always_comb begin
        if (wb_excp[5])      trap.ecode = `ECODE_INT;
        else if (wb_excp[4]) trap.ecode = `ECODE_ADEF;
        else if (wb_excp[2]) trap.ecode = `ECODE_SYS;
        else if (wb_excp[1]) trap.ecode = `ECODE_BRK;
        else if (wb_excp[0]) trap.ecode = `ECODE_INE;
        else                 trap.ecode = `ECODE_ALE;
    end

    assign trap.ex       = ex_now;
    assign trap.ertn     = ertn_now;
    assign trap.esubcode = wb_esubcode;
    assign trap.ex_pc    = wb_pc;

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
rtl/wb_pkg.sv
rtl/csr_port_if.sv
rtl/trap_if.sv
rtl/wb_stage.sv
rtl/csr_file.sv
rtl/stable_timer.sv
rtl/wb_csr_top.sv
verification/wb_csr_tb.sv

// File: verification/wb_csr_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "wb_config.svh"

module wb_csr_tb;
    import wb_pkg::*;

    localparam int TIMER_WAIT = 200; // cycles allowed for the timer interrupt
    localparam int CLEAR_WAIT = 10;

    logic        clk;
    logic        resetn;
    logic        mem_valid;
    pc_t         mem_pc;
    logic        mem_rf_we;
    reg_addr_t   mem_rf_waddr;
    word_t       mem_rf_wdata;
    logic        mem_csr_re;
    logic        mem_csr_we;
    csr_num_t    mem_csr_num;
    word_t       mem_csr_wmask;
    word_t       mem_csr_wvalue;
    logic        mem_ertn;
    excp_flags_t mem_excp;
    esubcode_t   mem_esubcode;
    cnt_op_t     mem_cnt_op;
    logic        rf_we;
    reg_addr_t   rf_waddr;
    word_t       rf_wdata;
    pc_t         debug_pc;
    logic        flush;
    pc_t         flush_target;
    logic        has_int;

    integer seed;
    int     errors;
    int     checks;
    int     tests;
    int     test_errs;

    wb_csr_top dut_i (
        .clk            (clk),
        .resetn         (resetn),
        .mem_valid      (mem_valid),
        .mem_pc         (mem_pc),
        .mem_rf_we      (mem_rf_we),
        .mem_rf_waddr   (mem_rf_waddr),
        .mem_rf_wdata   (mem_rf_wdata),
        .mem_csr_re     (mem_csr_re),
        .mem_csr_we     (mem_csr_we),
        .mem_csr_num    (mem_csr_num),
        .mem_csr_wmask  (mem_csr_wmask),
        .mem_csr_wvalue (mem_csr_wvalue),
        .mem_ertn       (mem_ertn),
        .mem_excp       (mem_excp),
        .mem_esubcode   (mem_esubcode),
        .mem_cnt_op     (mem_cnt_op),
        .rf_we          (rf_we),
        .rf_waddr       (rf_waddr),
        .rf_wdata       (rf_wdata),
        .debug_pc       (debug_pc),
        .flush          (flush),
        .flush_target   (flush_target),
        .has_int        (has_int)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic clear_inputs();
        mem_valid      <= 1'b0;
        mem_pc         <= '0;
        mem_rf_we      <= 1'b0;
        mem_rf_waddr   <= '0;
        mem_rf_wdata   <= '0;
        mem_csr_re     <= 1'b0;
        mem_csr_we     <= 1'b0;
        mem_csr_num    <= '0;
        mem_csr_wmask  <= '0;
        mem_csr_wvalue <= '0;
        mem_ertn       <= 1'b0;
        mem_excp       <= '0;
        mem_esubcode   <= '0;
        mem_cnt_op     <= `CNT_OP_NONE;
    endtask

    // presents one instruction for one cycle and returns mid-cycle while it is in writeback
    task automatic send_instr(input pc_t pc, input logic we_in, input reg_addr_t waddr,
                              input word_t wdata, input logic csr_re, input logic csr_we,
                              input csr_num_t num, input word_t wmask, input word_t wvalue,
                              input logic ertn, input excp_flags_t excp, input cnt_op_t op);
        @(posedge clk);
        mem_valid      <= 1'b1;
        mem_pc         <= pc;
        mem_rf_we      <= we_in;
        mem_rf_waddr   <= waddr;
        mem_rf_wdata   <= wdata;
        mem_csr_re     <= csr_re;
        mem_csr_we     <= csr_we;
        mem_csr_num    <= num;
        mem_csr_wmask  <= wmask;
        mem_csr_wvalue <= wvalue;
        mem_ertn       <= ertn;
        mem_excp       <= excp;
        mem_cnt_op     <= op;
        @(posedge clk);
        clear_inputs();
        @(negedge clk);
    endtask

    task automatic csr_write(input csr_num_t num, input word_t mask, input word_t value);
        send_instr(32'h1c00_0000, 1'b0, '0, '0, 1'b0, 1'b1, num, mask, value,
                   1'b0, '0, `CNT_OP_NONE);
    endtask

    task automatic csr_read(input csr_num_t num, output word_t value);
        send_instr(32'h1c00_0004, 1'b1, 5'd4, '0, 1'b1, 1'b0, num, '0, '0,
                   1'b0, '0, `CNT_OP_NONE);
        value = rf_wdata;
    endtask

    task automatic cnt_read(input cnt_op_t op, output word_t value);
        send_instr(32'h1c00_0008, 1'b1, 5'd5, '0, 1'b0, 1'b0, '0, '0, '0,
                   1'b0, '0, op);
        value = rf_wdata;
    endtask

    task automatic check(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR: %s", msg);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_errs) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_errs);
        end
        test_errs = errors;
    endtask

    task automatic test_reg_writeback();
        word_t pc;
        word_t rnd;
        word_t data;
        check("rf_we", word_t'(rf_we), 32'h0); // straight out of reset
        check("flush", word_t'(flush), 32'h0);
        for (int i = 0; i < 4; i++) begin
            pc = $random(seed);
            pc[1:0] = 2'b00;
            rnd = $random(seed);
            data = $random(seed);
            send_instr(pc, 1'b1, rnd[4:0], data, 1'b0, 1'b0, '0, '0, '0,
                       1'b0, '0, `CNT_OP_NONE);
            check("rf_we", word_t'(rf_we), 32'h1);
            check("rf_waddr", word_t'(rf_waddr), word_t'(rnd[4:0]));
            check("rf_wdata", rf_wdata, data);
            check("debug_pc", debug_pc, pc);
        end
        // write request without mem_valid
        @(posedge clk);
        mem_rf_we    <= 1'b1;
        mem_rf_wdata <= data;
        @(posedge clk);
        clear_inputs();
        @(negedge clk);
        check("rf_we", word_t'(rf_we), 32'h0);
        end_test("register_writeback");
    endtask

    task automatic test_csr_rw();
        word_t old_v;
        word_t new_v;
        word_t mask;
        word_t rd;
        old_v = $random(seed);
        new_v = $random(seed);
        mask  = 32'h00ff_ff00;
        csr_write(`CSR_SAVE0, 32'hffff_ffff, old_v);
        csr_read(`CSR_SAVE0, rd);
        check("save0", rd, old_v);
        csr_write(`CSR_SAVE0, mask, new_v);
        csr_read(`CSR_SAVE0, rd);
        check("save0", rd, (old_v & ~mask) | (new_v & mask));
        end_test("csr_read_write");
    endtask

    task automatic test_exception_entry();
        word_t rd;
        csr_write(`CSR_CRMD, 32'h7, 32'h4); // plv0, ie on
        csr_write(`CSR_EENTRY, 32'hffff_ffff, 32'h1c00_8000);
        send_instr(32'h1c00_0120, 1'b1, 5'd7, 32'h1234_5678, 1'b0, 1'b0, '0, '0, '0,
                   1'b0, 6'b000100, `CNT_OP_NONE);
        check("flush", word_t'(flush), 32'h1);
        check("flush_target", flush_target, 32'h1c00_8000);
        check("rf_we", word_t'(rf_we), 32'h0);
        csr_read(`CSR_ERA, rd);
        check("era", rd, 32'h1c00_0120);
        csr_read(`CSR_ESTAT, rd);
        check("estat.ecode", word_t'(rd[21:16]), word_t'(`ECODE_SYS));
        csr_read(`CSR_CRMD, rd);
        check("crmd.ie", word_t'(rd[2]), 32'h0);
        csr_read(`CSR_PRMD, rd);
        check("prmd.pie", word_t'(rd[2]), 32'h1);
        end_test("exception_entry");
    endtask

    task automatic test_exception_priority();
        excp_flags_t flags [6];
        ecode_t      codes [6];
        word_t       rd;
        // each row drops the highest cause of the row above
        flags = '{6'b111111, 6'b011111, 6'b001111, 6'b001011, 6'b001001, 6'b001000};
        codes = '{`ECODE_INT, `ECODE_ADEF, `ECODE_SYS, `ECODE_BRK, `ECODE_INE, `ECODE_ALE};
        for (int i = 0; i < 6; i++) begin
            send_instr(32'h1c00_0300, 1'b0, '0, '0, 1'b0, 1'b0, '0, '0, '0,
                       1'b0, flags[i], `CNT_OP_NONE);
            check("flush", word_t'(flush), 32'h1);
            csr_read(`CSR_ESTAT, rd);
            check("estat.ecode", word_t'(rd[21:16]), word_t'(codes[i]));
        end
        end_test("exception_priority");
    endtask

    task automatic test_exception_return();
        word_t rd;
        csr_write(`CSR_PRMD, 32'h7, 32'h7); // pplv 3, pie on
        csr_write(`CSR_ERA, 32'hffff_ffff, 32'h1c00_2468);
        send_instr(32'h1c00_0200, 1'b0, '0, '0, 1'b0, 1'b0, '0, '0, '0,
                   1'b1, '0, `CNT_OP_NONE);
        check("flush", word_t'(flush), 32'h1);
        check("flush_target", flush_target, 32'h1c00_2468);
        csr_read(`CSR_CRMD, rd);
        check("crmd.plv", word_t'(rd[1:0]), 32'h3);
        check("crmd.ie", word_t'(rd[2]), 32'h1);
        end_test("exception_return");
    endtask

    task automatic test_timer_counters();
        int    n;
        word_t c0;
        word_t c1;
        word_t tid_v;
        word_t rd;
        csr_write(`CSR_ECFG, 32'h800, 32'h800);
        csr_write(`CSR_CRMD, 32'h7, 32'h4);
        csr_write(`CSR_TCFG, 32'hffff_ffff, 32'h0000_0021); // one-shot, count 32
        check("has_int", word_t'(has_int), 32'h0); // countdown has only just started
        n = 0;
        while (!has_int && n < TIMER_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (!has_int) report_error("has_int did not rise after the timer was started");
        csr_write(`CSR_TICLR, 32'h1, 32'h1);
        n = 0;
        while (has_int && n < CLEAR_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (has_int) report_error("has_int stayed high after the TICLR write");
        cnt_read(`CNT_OP_VL, c0);
        cnt_read(`CNT_OP_VL, c1);
        check("counter increasing", word_t'(c1 > c0), 32'h1);
        tid_v = $random(seed);
        csr_write(`CSR_TID, 32'hffff_ffff, tid_v);
        cnt_read(`CNT_OP_TID, rd);
        check("rdcntid", rd, tid_v);
        end_test("timer_counters");
    endtask

    initial begin
        seed      = 32'hd2ab_2014;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        test_errs = 0;
        resetn   <= 1'b0;
        clear_inputs();
        repeat (10) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        test_reg_writeback();
        test_csr_rw();
        test_exception_entry();
        test_exception_priority();
        test_exception_return();
        test_timer_counters();
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
